// File: chart_pixel_top.f
+incdir+include
source/raster_pkg.sv
source/chart_pkg.sv
source/chart_setup_stage.sv
source/optotype_raster.sv
source/result_raster.sv
source/ink_select_stage.sv
source/chart_pixel_top.sv
testbench/tb_clock_gen.sv
testbench/tb_chart_pixel.sv

// File: include/chart_config.svh
`ifndef CHART_CONFIG_SVH
`define CHART_CONFIG_SVH

`define CHART_COORD_W 12

// tumbling E anchor
`define CHART_E_ORG_X 40
`define CHART_E_ORG_Y 180

`define CHART_BAR 6

// seven-segment score boxes
`define CHART_DIG_L_X 200
`define CHART_DIG_R_X 340
`define CHART_DIG_W 100
`define CHART_ROW_TOP 140
`define CHART_ROW_MID 237
`define CHART_ROW_BOT 334
`define CHART_ROW_END 340
`define CHART_ONE_X0 244
`define CHART_DOT_X0 317
`define CHART_DOT_X1 322

// verdict letters
`define CHART_YES_X0 280
`define CHART_YES_X1 360
`define CHART_YES_Y0 185
`define CHART_YES_Y1 295
`define CHART_NO_X0 265
`define CHART_NO_X1 375
`define CHART_NO_Y0 186
`define CHART_NO_Y1 294

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the chart pixel testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f chart_pixel_top.f --top-module tb_chart_pixel \
	-o sim_chart > build.log 2>&1 && ./obj_dir/sim_chart > sim.log 2>&1
grep -q "All tests passed!" sim.log && echo "simulation passed" || {
	echo "simulation failed, see build.log and sim.log"
	exit 1
}

// File: source/chart_pixel_top.sv
module chart_pixel_top
	import raster_pkg::*;
	import chart_pkg::*;
(
	input  logic          i_clk,
	input  logic          i_rst,
	input  pixel_req_t    i_pixel,
	input  test_mode_t    i_mode,
	input  acuity_level_t i_level,
	input  e_direction_t  i_direction,
	input  logic          i_done,
	input  logic          i_result,
	output logic          o_ink
);

	setup_t   setup;
	view_t    view;
	logic     e_ink, score_ink, verdict_ink;
	ink_set_t inks;

	chart_setup_stage u_setup (
		.i_clk       (i_clk),
		.i_rst       (i_rst),
		.i_pixel     (i_pixel),
		.i_mode      (i_mode),
		.i_level     (i_level),
		.i_direction (i_direction),
		.i_done      (i_done),
		.i_result    (i_result),
		.o_setup     (setup)
	);

	optotype_raster u_optotype (
		.i_clk   (i_clk),
		.i_rst   (i_rst),
		.i_setup (setup),
		.o_e_ink (e_ink)
	);

	result_raster u_result (
		.i_clk         (i_clk),
		.i_rst         (i_rst),
		.i_setup       (setup),
		.o_score_ink   (score_ink),
		.o_verdict_ink (verdict_ink),
		.o_view        (view)
	);

	assign inks = '{view: view, e_ink: e_ink, score_ink: score_ink, verdict_ink: verdict_ink};

	ink_select_stage u_select (
		.i_clk  (i_clk),
		.i_rst  (i_rst),
		.i_inks (inks),
		.o_ink  (o_ink)
	);

endmodule

// File: source/chart_pkg.sv
package chart_pkg;

	// only two modes are drawn, all other codes are invalid
	typedef enum logic [2:0] {
		VISION  = 3'd1,
		VERDICT = 3'd3
	} test_mode_t;

	// 0 is acuity 0.1, 12 is acuity 2.0
	typedef logic [3:0] acuity_level_t;

	typedef enum logic [1:0] {
		UP,
		DOWN,
		LEFT,
		RIGHT
	} e_direction_t;

	typedef struct packed {
		logic [6:0] side;
		logic [4:0] near_m;
		logic [4:0] far_m;
		logic [4:0] slot;
	} e_geometry_t;

	typedef enum logic [2:0] {
		VIEW_E,
		VIEW_SCORE,
		VIEW_YES,
		VIEW_NO,
		VIEW_BLANK
	} view_t;

	// stage 1 result
	typedef struct packed {
		raster_pkg::pixel_req_t pixel;
		view_t                  view;
		e_geometry_t            geom;
		e_direction_t           dir;
		logic [3:0]             digit_l;
		logic [3:0]             digit_r;
	} setup_t;

	// stage 2 result
	typedef struct packed {
		view_t view;
		logic  e_ink;
		logic  score_ink;
		logic  verdict_ink;
	} ink_set_t;

endpackage

// File: source/chart_setup_stage.sv
module chart_setup_stage
	import raster_pkg::*;
	import chart_pkg::*;
(
	input  logic          i_clk,
	input  logic          i_rst,
	input  pixel_req_t    i_pixel,
	input  test_mode_t    i_mode,
	input  acuity_level_t i_level,
	input  e_direction_t  i_direction,
	input  logic          i_done,
	input  logic          i_result,
	output setup_t        o_setup
);

	typedef struct packed {
		e_geometry_t geom;
		logic [3:0]  digit_l;
		logic [3:0]  digit_r;
		logic        valid;
	} level_row_t;

	level_row_t row;
	view_t      view_d;

	// side, near, far, slot, then the score digits
	always_comb begin
		case (i_level)
			4'd0:    row = '{'{7'd120, 5'd24, 5'd24, 5'd24}, 4'd0, 4'd1, 1'b1};
			4'd1:    row = '{'{7'd60, 5'd12, 5'd12, 5'd12}, 4'd0, 4'd2, 1'b1};
			4'd2:    row = '{'{7'd40, 5'd8, 5'd8, 5'd8}, 4'd0, 4'd3, 1'b1};
			4'd3:    row = '{'{7'd30, 5'd6, 5'd6, 5'd6}, 4'd0, 4'd4, 1'b1};
			4'd4:    row = '{'{7'd24, 5'd5, 5'd5, 5'd5}, 4'd0, 4'd5, 1'b1};
			4'd5:    row = '{'{7'd20, 5'd4, 5'd4, 5'd4}, 4'd0, 4'd6, 1'b1};
			4'd6:    row = '{'{7'd17, 5'd3, 5'd3, 5'd4}, 4'd0, 4'd7, 1'b1};
			4'd7:    row = '{'{7'd15, 5'd3, 5'd3, 5'd3}, 4'd0, 4'd8, 1'b1};
			4'd8:    row = '{'{7'd13, 5'd3, 5'd3, 5'd2}, 4'd0, 4'd9, 1'b1};
			4'd9:    row = '{'{7'd12, 5'd2, 5'd2, 5'd3}, 4'd1, 4'd0, 1'b1};
			4'd10:   row = '{'{7'd10, 5'd2, 5'd2, 5'd2}, 4'd1, 4'd2, 1'b1};
			4'd11:   row = '{'{7'd8, 5'd2, 5'd2, 5'd1}, 4'd1, 4'd5, 1'b1};
			4'd12:   row = '{'{7'd6, 5'd1, 5'd1, 5'd1}, 4'd2, 4'd0, 1'b1};
			default: row = '0;
		endcase
	end

	always_comb begin
		case (i_mode)
			VISION: begin
				if (!row.valid)
					view_d = VIEW_BLANK;
				else if (i_done)
					view_d = VIEW_SCORE;
				else
					view_d = VIEW_E;
			end
			VERDICT: view_d = i_result ? VIEW_NO : VIEW_YES;
			default: view_d = VIEW_BLANK;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_setup <= '{pixel: '0, view: VIEW_BLANK, geom: '0, dir: UP,
				digit_l: 4'd0, digit_r: 4'd0};
		end else begin
			o_setup <= '{pixel: i_pixel, view: view_d, geom: row.geom, dir: i_direction,
				digit_l: row.digit_l, digit_r: row.digit_r};
		end
	end

endmodule

// File: source/ink_select_stage.sv
module ink_select_stage
	import chart_pkg::*;
(
	input  logic     i_clk,
	input  logic     i_rst,
	input  ink_set_t i_inks,
	output logic     o_ink
);

	logic ink_d;

	always_comb begin
		case (i_inks.view)
			VIEW_E:           ink_d = i_inks.e_ink;
			VIEW_SCORE:       ink_d = i_inks.score_ink;
			VIEW_YES, VIEW_NO: ink_d = i_inks.verdict_ink;
			// invalid state draws black
			default:          ink_d = 1'b0;
		endcase
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst)
			o_ink <= 1'b1;
		else
			o_ink <= ink_d;
	end

endmodule

// File: source/optotype_raster.sv
`include "chart_config.svh"

module optotype_raster
	import raster_pkg::*;
	import chart_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst,
	input  setup_t i_setup,
	output logic   o_e_ink
);

	coord_t x, y, side, near_m, far_m, slot;
	coord_t a, b, a_org, b_org;
	logic   in_box, in_slot, open;

	assign x      = i_setup.pixel.x;
	assign y      = i_setup.pixel.y;
	assign side   = coord_t'(i_setup.geom.side);
	assign near_m = coord_t'(i_setup.geom.near_m);
	assign far_m  = coord_t'(i_setup.geom.far_m);
	assign slot   = coord_t'(i_setup.geom.slot);

	assign in_box = x >= `CHART_E_ORG_X && x <= `CHART_E_ORG_X + side &&
		y >= `CHART_E_ORG_Y && y <= `CHART_E_ORG_Y + side;

	// slots run along a, the opening faces along b
	always_comb begin
		if (i_setup.dir == UP || i_setup.dir == DOWN) begin
			a     = x;
			b     = y;
			a_org = coord_t'(`CHART_E_ORG_X);
			b_org = coord_t'(`CHART_E_ORG_Y);
		end else begin
			a     = y;
			b     = x;
			a_org = coord_t'(`CHART_E_ORG_Y);
			b_org = coord_t'(`CHART_E_ORG_X);
		end
	end

	assign in_slot = (a >= a_org + near_m && a <= a_org + near_m + slot) ||
		(a >= a_org + side - far_m - slot && a <= a_org + side - far_m);

	assign open = (i_setup.dir == UP || i_setup.dir == LEFT) ?
		(b <= b_org + side - near_m) : (b >= b_org + near_m);

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst)
			o_e_ink <= 1'b1;
		else
			o_e_ink <= !in_box || (in_slot && open);
	end

endmodule

// File: source/raster_pkg.sv
`include "chart_config.svh"

package raster_pkg;

	// one screen axis
	typedef logic [`CHART_COORD_W-1:0] coord_t;

	// pixel coming from the raster scanner
	typedef struct packed {
		coord_t x;
		coord_t y;
	} pixel_req_t;

endpackage

// File: source/result_raster.sv
`include "chart_config.svh"

module result_raster
	import raster_pkg::*;
	import chart_pkg::*;
(
	input  logic   i_clk,
	input  logic   i_rst,
	input  setup_t i_setup,
	output logic   o_score_ink,
	output logic   o_verdict_ink,
	output view_t  o_view
);

	coord_t x, y;
	logic signed [`CHART_COORD_W:0] diff;
	logic [`CHART_COORD_W:0] sum;
	logic dot, lit_l, lit_r, yes_ink, no_ink;

	// true when the pixel sits on a lit bar of the digit in the box at x0
	function automatic logic digit_lit(input coord_t px, input coord_t py, input coord_t x0,
		input logic [3:0] digit, input logic centre_one);
		logic [6:0] seg;
		logic wide, left_v, right_v, upper, lower, centre;
		begin
			// a b c d e f g
			case (digit)
				4'd0:    seg = 7'b1111110;
				4'd1:    seg = 7'b0110000;
				4'd2:    seg = 7'b1101101;
				4'd3:    seg = 7'b1111001;
				4'd4:    seg = 7'b0110011;
				4'd5:    seg = 7'b1011011;
				4'd6:    seg = 7'b1011111;
				4'd7:    seg = 7'b1110000;
				4'd8:    seg = 7'b1111111;
				4'd9:    seg = 7'b1111011;
				default: seg = 7'b0000000;
			endcase
			wide    = px > x0 && px <= x0 + `CHART_DIG_W;
			left_v  = px > x0 && px <= x0 + `CHART_BAR;
			right_v = px > x0 + `CHART_DIG_W - `CHART_BAR && px <= x0 + `CHART_DIG_W;
			upper   = py > `CHART_ROW_TOP + `CHART_BAR && py <= `CHART_ROW_MID;
			lower   = py > `CHART_ROW_MID + `CHART_BAR && py <= `CHART_ROW_BOT;
			centre  = px > `CHART_ONE_X0 && px <= `CHART_ONE_X0 + `CHART_BAR;
			if (centre_one && digit == 4'd1)
				digit_lit = centre && (upper || lower);
			else
				digit_lit = (seg[6] && wide && py > `CHART_ROW_TOP &&
						py <= `CHART_ROW_TOP + `CHART_BAR) ||
					(seg[5] && right_v && upper) ||
					(seg[4] && right_v && lower) ||
					(seg[3] && wide && py > `CHART_ROW_BOT && py <= `CHART_ROW_END) ||
					(seg[2] && left_v && lower) ||
					(seg[1] && left_v && upper) ||
					(seg[0] && wide && py > `CHART_ROW_MID &&
						py <= `CHART_ROW_MID + `CHART_BAR);
		end
	endfunction

	assign x    = i_setup.pixel.x;
	assign y    = i_setup.pixel.y;
	assign sum  = {1'b0, x} + {1'b0, y};
	assign diff = $signed({1'b0, x}) - $signed({1'b0, y});

	assign lit_l = digit_lit(x, y, coord_t'(`CHART_DIG_L_X), i_setup.digit_l, 1'b1);
	assign lit_r = digit_lit(x, y, coord_t'(`CHART_DIG_R_X), i_setup.digit_r, 1'b0);
	assign dot   = x >= `CHART_DOT_X0 && x <= `CHART_DOT_X1 &&
		y > `CHART_ROW_BOT && y <= `CHART_ROW_END;

	// Y is two diagonals meeting at x 320 over a vertical stem
	always_comb begin
		yes_ink = 1'b1;
		if (x >= `CHART_YES_X0 && x <= `CHART_YES_X1 &&
			y >= `CHART_YES_Y0 && y <= `CHART_YES_Y1) begin
			if (x >= 320 && y <= 225 && sum >= 538 && sum <= 548)
				yes_ink = 1'b0;
			else if (x <= 320 && y <= 225 && diff >= 88 && diff <= 98)
				yes_ink = 1'b0;
			else if (x >= 317 && x <= 323 && y >= 225)
				yes_ink = 1'b0;
		end
	end

	always_comb begin
		no_ink = 1'b1;
		if (x >= `CHART_NO_X0 && x <= `CHART_NO_X1 &&
			y >= `CHART_NO_Y0 && y <= `CHART_NO_Y1) begin
			if (x <= 272 || x >= 368 || (diff >= 74 && diff <= 86))
				no_ink = 1'b0;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst) begin
		if (!i_rst) begin
			o_score_ink   <= 1'b1;
			o_verdict_ink <= 1'b1;
			o_view        <= VIEW_BLANK;
		end else begin
			o_score_ink   <= !(lit_l || lit_r || dot);
			o_verdict_ink <= (i_setup.view == VIEW_NO) ? no_ink : yes_ink;
			o_view        <= i_setup.view;
		end
	end

endmodule

// File: testbench/tb_chart_pixel.sv
`include "chart_config.svh"

module tb_chart_pixel
	import raster_pkg::*;
	import chart_pkg::*;
();

	typedef struct {
		string         name;
		pixel_req_t    pixel;
		test_mode_t    mode;
		acuity_level_t level;
		e_direction_t  dir;
		logic          done;
		logic          result;
		logic          exp_ink;
	} row_t;

	localparam int e_org_x = `CHART_E_ORG_X;
	localparam int e_org_y = `CHART_E_ORG_Y;

	// level table: E geometry and score digits
	int e_side[13] = '{120, 60, 40, 30, 24, 20, 17, 15, 13, 12, 10, 8, 6};
	int e_near[13] = '{24, 12, 8, 6, 5, 4, 3, 3, 3, 2, 2, 2, 1};
	int e_far[13]  = '{24, 12, 8, 6, 5, 4, 3, 3, 3, 2, 2, 2, 1};
	int e_slot[13] = '{24, 12, 8, 6, 5, 4, 4, 3, 2, 3, 2, 1, 1};
	int dig_l[13]  = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 1, 2};
	int dig_r[13]  = '{1, 2, 3, 4, 5, 6, 7, 8, 9, 0, 2, 5, 0};
	// gfedcba
	logic [6:0] seg_mask[10] = '{7'h3f, 7'h06, 7'h5b, 7'h4f, 7'h66, 7'h6d, 7'h7d,
		7'h07, 7'h7f, 7'h6f};

	int score_px[9] = '{250, 390, 203, 437, 203, 320, 250, 390, 247};
	int score_py[9] = '{143, 143, 200, 200, 300, 338, 190, 240, 200};
	int ver_px[10]  = '{300, 330, 320, 290, 270, 268, 370, 300, 320, 250};
	int ver_py[10]  = '{205, 213, 260, 260, 200, 250, 250, 220, 200, 250};
	int e_levels[3] = '{0, 6, 12};
	int pipe_modes[4] = '{1, 3, 0, 3};

	logic          clk, rst, o_ink, timed_out;
	pixel_req_t    pixel;
	test_mode_t    mode;
	acuity_level_t level;
	e_direction_t  direction;
	logic          done, result;
	row_t          rows[$];
	integer        seed;
	int            n_checks, n_errors;

	tb_clock_gen clock0 (.o_clk(clk), .o_rst(rst));

	chart_pixel_top dut0 (
		.i_clk       (clk),
		.i_rst       (rst),
		.i_pixel     (pixel),
		.i_mode      (mode),
		.i_level     (level),
		.i_direction (direction),
		.i_done      (done),
		.i_result    (result),
		.o_ink       (o_ink)
	);

	function automatic logic optotype_ink(int x, int y, int lv, int dir);
		int s, a, b, ao, bo, lo1, lo2;
		logic in_slot, open;
		s = e_side[lv];
		if (x < e_org_x || x > e_org_x + s || y < e_org_y || y > e_org_y + s)
			return 1'b1;
		a = (dir < 2) ? x : y;
		b = (dir < 2) ? y : x;
		ao = (dir < 2) ? e_org_x : e_org_y;
		bo = (dir < 2) ? e_org_y : e_org_x;
		lo1 = ao + e_near[lv];
		lo2 = ao + s - e_far[lv] - e_slot[lv];
		in_slot = (a >= lo1 && a <= lo1 + e_slot[lv]) || (a >= lo2 && a <= lo2 + e_slot[lv]);
		// up and left open toward the far side of b
		open = (dir == 0 || dir == 2) ? (b <= bo + s - e_near[lv]) : (b >= bo + e_near[lv]);
		return in_slot && open;
	endfunction

	function automatic logic segment_hit(int x, int y, int x0, int d, logic is_left);
		logic [6:0] m;
		logic in_w, vl, vr, up, lo;
		m = seg_mask[d];
		in_w = x > x0 && x <= x0 + 100;
		vl = x > x0 && x <= x0 + 6;
		vr = x > x0 + 94 && x <= x0 + 100;
		up = y > 146 && y <= 237;
		lo = y > 243 && y <= 334;
		if (is_left && d == 1)
			return x > 244 && x <= 250 && (up || lo);
		return (m[0] && in_w && y > 140 && y <= 146) || (m[6] && in_w && y > 237 && y <= 243) ||
			(m[3] && in_w && y > 334 && y <= 340) || (m[1] && vr && up) ||
			(m[2] && vr && lo) || (m[4] && vl && lo) || (m[5] && vl && up);
	endfunction

	function automatic logic verdict_ink(int x, int y, int is_no);
		if (is_no == 0) begin
			if (x < 280 || x > 360 || y < 185 || y > 295)
				return 1'b1;
			return !((x >= 320 && y <= 225 && x + y >= 538 && x + y <= 548) ||
				(x <= 320 && y <= 225 && x - y >= 88 && x - y <= 98) ||
				(x >= 317 && x <= 323 && y >= 225));
		end
		if (x < 265 || x > 375 || y < 186 || y > 294)
			return 1'b1;
		return !(x <= 272 || x >= 368 || (x - y >= 74 && x - y <= 86));
	endfunction

	function automatic logic expected_ink(int x, int y, int md, int lv, int dir, int dn, int res);
		if (md == 3)
			return verdict_ink(x, y, res);
		// invalid mode or level draws black
		if (md != 1 || lv > 12)
			return 1'b0;
		if (dn == 0)
			return optotype_ink(x, y, lv, dir);
		return !(segment_hit(x, y, 200, dig_l[lv], 1'b1) ||
			segment_hit(x, y, 340, dig_r[lv], 1'b0) ||
			(x >= 317 && x <= 322 && y > 334 && y <= 340));
	endfunction

	task automatic add_row(input string name, input int x, input int y, input int md,
		input int lv, input int dir, input int dn, input int res);
		row_t r;
		r.name = name;
		r.pixel = '{x: coord_t'(x), y: coord_t'(y)};
		r.mode = test_mode_t'(md[2:0]);
		r.level = acuity_level_t'(lv[3:0]);
		r.dir = e_direction_t'(dir[1:0]);
		r.done = dn[0];
		r.result = res[0];
		r.exp_ink = expected_ink(x, y, md, lv, dir, dn, res);
		rows.push_back(r);
	endtask

	task automatic add_e_rows(input int lv);
		int s, m, xn, yn, xf, yf;
		s = e_side[lv];
		m = e_near[lv];
		for (int d = 0; d < 4; d++) begin
			// slot pixels just past either end of the opening axis
			if (d < 2) begin
				xn = e_org_x + m + 1;
				yn = e_org_y + m - 1;
				xf = xn;
				yf = e_org_y + s - m + 1;
			end else begin
				xn = e_org_x + m - 1;
				yn = e_org_y + m + 1;
				xf = e_org_x + s - m + 1;
				yf = yn;
			end
			add_row("e_slot", e_org_x + m + 1, e_org_y + m + 1, 1, lv, d, 0, 0);
			add_row("e_corner", e_org_x, e_org_y, 1, lv, d, 0, 0);
			add_row("e_far_corner", e_org_x + s, e_org_y + s, 1, lv, d, 0, 0);
			add_row("e_spine", e_org_x + s / 2, e_org_y + s / 2, 1, lv, d, 0, 0);
			add_row("e_outside", e_org_x - 1, e_org_y + s / 2, 1, lv, d, 0, 0);
			add_row("e_near_end", xn, yn, 1, lv, d, 0, 0);
			add_row("e_far_end", xf, yf, 1, lv, d, 0, 0);
		end
	endtask

	task automatic check_ink(input string name, input logic exp, input logic act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("[FAIL] %s expected %0b actual %0b", name, exp, act);
		end
	endtask

	initial begin
		int wait_cycles;
		int n;
		seed = 32'hc73a_e5a8;
		n_checks = 0;
		n_errors = 0;
		timed_out = 1'b0;
		pixel = '0;
		mode = test_mode_t'(3'd0);
		level = '0;
		direction = UP;
		done = 1'b0;
		result = 1'b0;

		foreach (e_levels[i])
			add_e_rows(e_levels[i]);
		foreach (score_px[i]) begin
			add_row("score_0_4", score_px[i], score_py[i], 1, 3, 0, 1, 0);
			add_row("score_1_0", score_px[i], score_py[i], 1, 9, 0, 1, 0);
			add_row("score_2_0", score_px[i], score_py[i], 1, 12, 0, 1, 0);
		end
		foreach (ver_px[i]) begin
			add_row("verdict_yes", ver_px[i], ver_py[i], 3, 0, 0, 0, 0);
			add_row("verdict_no", ver_px[i], ver_py[i], 3, 0, 0, 0, 1);
		end
		add_row("bad_level_13", 70, 200, 1, 13, 0, 0, 0);
		add_row("bad_level_15", 250, 190, 1, 15, 0, 1, 0);
		add_row("bad_mode_0", 290, 260, 0, 3, 0, 0, 0);
		add_row("bad_mode_2", 320, 200, 2, 3, 0, 1, 1);
		add_row("bad_mode_7", 65, 205, 7, 0, 0, 0, 0);
		for (int i = 0; i < 12; i++)
			add_row("pipeline", 300 + 4 * i, 200 + 8 * i, pipe_modes[i % 4], 3, 0, i % 2, i % 2);
		for (int i = 0; i < 60; i++)
			add_row("random", $random(seed) & 511, 100 + ($random(seed) & 255),
				($random(seed) & 1) ? 1 : 3, $random(seed) & 15, $random(seed) & 3,
				$random(seed) & 1, $random(seed) & 1);
		n = rows.size();

		// white while reset is held
		wait_cycles = 0;
		while (!rst && wait_cycles < 50) begin
			@(negedge clk);
			check_ink("reset", 1'b1, o_ink);
			wait_cycles++;
		end

		if (!rst) begin
			$display("timeout: reset still asserted after %0d cycles", wait_cycles);
			timed_out = 1'b1;
		end else begin
			for (int i = 0; i < n + 3; i++) begin
				@(posedge clk);
				if (i < n) begin
					pixel <= rows[i].pixel;
					mode <= rows[i].mode;
					level <= rows[i].level;
					direction <= rows[i].dir;
					done <= rows[i].done;
					result <= rows[i].result;
				end
				@(negedge clk);
				// blank stage registers drain first
				if (i < 3)
					check_ink("post_reset_blank", 1'b0, o_ink);
				else
					check_ink($sformatf("%s row %0d", rows[i - 3].name, i - 3),
						rows[i - 3].exp_ink, o_ink);
			end
		end

		$display("checks: %0d, errors: %0d", n_checks, n_errors);
		if (n_errors == 0 && !timed_out)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
	output logic o_clk,
	output logic o_rst
);

	initial begin
		o_clk = 1'b0;
		forever #10 o_clk = !o_clk;
	end

	// release a quarter period after the tenth rising edge
	initial begin
		o_rst = 1'b0;
		repeat (10) @(posedge o_clk);
		#5 o_rst = 1'b1;
	end

endmodule
